// ==== booth_multiplier.f ====
logic/booth_pkg.sv
logic/booth_controller.sv
logic/operand_select.sv
logic/multiplier_scan.sv
logic/product_accumulator.sv
logic/booth_multiplier.sv
tb/booth_multiplier_tb.sv

// ==== logic/booth_controller.sv ====
module booth_controller (
    input  logic       clk,
    input  logic       rst,
    input  logic       src_valid,
    input  logic       dest_ready,
    input  logic       count_comp,
    input  logic [1:0] booth_window,
    output logic       src_ready,
    output logic       dest_valid,
    output logic       load,
    output logic       step,
    output logic       qr_sel,
    output logic       clear,
    output logic [1:0] data_sel
);

    booth_pkg::state_t state;
    booth_pkg::state_t next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= booth_pkg::start;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        src_ready = 1'b0;
        dest_valid = 1'b0;
        load = 1'b0;
        step = 1'b0;
        qr_sel = 1'b0;
        clear = 1'b0;
        data_sel = booth_pkg::add_zero;

        case (state)
            booth_pkg::start: begin
                src_ready = 1'b1;
                clear = 1'b1;  // accumulator sits at zero while idle
                if (src_valid) begin
                    load = 1'b1;
                    next_state = booth_pkg::process;
                end
            end

            booth_pkg::process: begin
                step = 1'b1;
                qr_sel = 1'b1;
                case (booth_window)
                    2'b01: begin
                        data_sel = booth_pkg::add_plus;
                    end
                    2'b10: begin
                        data_sel = booth_pkg::add_minus;
                    end
                    2'b11: begin
                        data_sel = booth_pkg::add_zero_alt;
                    end
                    default: begin
                        data_sel = booth_pkg::add_zero;
                    end
                endcase
                // last shift lands at this edge, product is offered after it
                if (count_comp) begin
                    next_state = booth_pkg::wait_out;
                end
            end

            booth_pkg::wait_out: begin
                dest_valid = 1'b1;  // datapath frozen so the product holds
                if (dest_ready) begin
                    next_state = booth_pkg::start;
                end
            end

            default: begin
                next_state = booth_pkg::start;
            end
        endcase
    end

    // one transaction in flight at a time
    valid_ready_exclusive: assert property (
        @(posedge clk) disable iff (!rst)
        !(dest_valid && src_ready)
    );

    // the offered product is held until the sink takes it
    hold_until_taken: assert property (
        @(posedge clk) disable iff (!rst)
        (dest_valid && !dest_ready) |=> (state == booth_pkg::wait_out)
    );

endmodule

// ==== logic/booth_multiplier.sv ====
module booth_multiplier (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 src_valid,
    output logic                                 src_ready,
    input  logic signed [booth_pkg::width-1:0]   multiplicand,
    input  logic signed [booth_pkg::width-1:0]   multiplier,
    output logic                                 dest_valid,
    input  logic                                 dest_ready,
    output logic signed [2*booth_pkg::width-1:0] product
);

    // controls from the FSM
    logic load;
    logic step;
    logic qr_sel;
    logic clear;
    logic [1:0] data_sel;

    // status back to the FSM
    logic [1:0] booth_window;
    logic count_comp;

    // datapath between the blocks
    logic signed [booth_pkg::width:0] addend;
    logic [booth_pkg::width-1:0] q_lo;
    logic shift_in;

    booth_controller booth_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .src_valid    (src_valid),
        .dest_ready   (dest_ready),
        .count_comp   (count_comp),
        .booth_window (booth_window),
        .src_ready    (src_ready),
        .dest_valid   (dest_valid),
        .load         (load),
        .step         (step),
        .qr_sel       (qr_sel),
        .clear        (clear),
        .data_sel     (data_sel)
    );

    operand_select operand_select_inst (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .multiplicand (multiplicand),
        .data_sel     (data_sel),
        .addend       (addend)
    );

    multiplier_scan multiplier_scan_inst (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .step         (step),
        .multiplier   (multiplier),
        .shift_in     (shift_in),
        .booth_window (booth_window),
        .count_comp   (count_comp),
        .q_lo         (q_lo)
    );

    product_accumulator product_accumulator_inst (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .step     (step),
        .qr_sel   (qr_sel),
        .addend   (addend),
        .q_lo     (q_lo),
        .shift_in (shift_in),
        .product  (product)
    );

endmodule

// ==== logic/booth_pkg.sv ====
package booth_pkg;

    localparam int width = 8;  // the product is twice this wide
    localparam int count_bits = $clog2(width + 1);  // counter has to reach width

    // addend codes use the booth window patterns {q0, q_minus1}
    localparam logic [1:0] add_zero = 2'b00;
    localparam logic [1:0] add_plus = 2'b01;
    localparam logic [1:0] add_minus = 2'b10;
    localparam logic [1:0] add_zero_alt = 2'b11;

    typedef enum logic [1:0] {
        start = 2'b00,
        process = 2'b01,
        wait_out = 2'b10
    } state_t;

    // high half is the accumulator A, low half is the multiplier Q
    typedef struct packed {
        logic signed [width-1:0] hi;
        logic [width-1:0] lo;
    } product_halves_t;

    // one word for the shift, two halves for the add
    typedef union packed {
        logic signed [2*width-1:0] full;
        product_halves_t halves;
    } product_u;

endpackage

// ==== logic/multiplier_scan.sv ====
module multiplier_scan (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load,
    input  logic                               step,
    input  logic signed [booth_pkg::width-1:0] multiplier,
    input  logic                               shift_in,
    output logic [1:0]                         booth_window,
    output logic                               count_comp,
    output logic [booth_pkg::width-1:0]        q_lo
);

    logic [booth_pkg::width-1:0] q_q;
    logic q_minus1;  // bit below q0
    logic [booth_pkg::count_bits-1:0] count_q;

    // Q shifts right, the low bit of the sum comes in at the top
    always_ff @(posedge clk) begin
        if (load) begin
            q_q <= multiplier;
        end else if (step) begin
            q_q <= {shift_in, q_q[booth_pkg::width-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            q_minus1 <= 1'b0;
            count_q <= '0;
        end else if (load) begin
            q_minus1 <= 1'b0;
            count_q <= '0;
        end else if (step) begin
            q_minus1 <= q_q[0];
            count_q <= count_q + 1'b1;
        end
    end

    assign booth_window = {q_q[0], q_minus1};
    assign q_lo = q_q;

    // high during the step that finishes the product
    assign count_comp = (count_q == booth_pkg::count_bits'(booth_pkg::width - 1));

    no_step_past_end: assert property (
        @(posedge clk) disable iff (!rst)
        step |-> (count_q != booth_pkg::count_bits'(booth_pkg::width))
    );

endmodule

// ==== logic/operand_select.sv ====
module operand_select (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               load,
    input  logic signed [booth_pkg::width-1:0] multiplicand,
    input  logic [1:0]                         data_sel,
    output logic signed [booth_pkg::width:0]   addend
);

    logic signed [booth_pkg::width-1:0] mcand_q;
    logic signed [booth_pkg::width:0] mcand_ext;

    always_ff @(posedge clk) begin
        if (load) begin
            mcand_q <= multiplicand;
        end
    end

    // one extra bit so the negated most negative value does not wrap
    assign mcand_ext = {mcand_q[booth_pkg::width-1], mcand_q};

    always_comb begin
        case (data_sel)
            booth_pkg::add_plus: begin
                addend = mcand_ext;
            end
            booth_pkg::add_minus: begin
                addend = -mcand_ext;  // two's complement
            end
            booth_pkg::add_zero, booth_pkg::add_zero_alt: begin
                addend = '0;
            end
            default: begin
                addend = '0;
            end
        endcase
    end

    // the addend code is settled while the operands are taken in
    sel_stable_at_load: assert property (
        @(posedge clk) disable iff (!rst)
        load |-> $stable(data_sel)
    );

endmodule

// ==== logic/product_accumulator.sv ====
module product_accumulator (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 clear,
    input  logic                                 step,
    input  logic                                 qr_sel,
    input  logic signed [booth_pkg::width:0]     addend,
    input  logic [booth_pkg::width-1:0]          q_lo,
    output logic                                 shift_in,
    output logic signed [2*booth_pkg::width-1:0] product
);

    logic signed [booth_pkg::width-1:0] hi_q;  // accumulator A
    logic signed [booth_pkg::width:0] sum;

    booth_pkg::product_u step_word;
    booth_pkg::product_u shifted;
    booth_pkg::product_u prod_word;

    // A plus addend in one extra bit so the sign survives the add
    assign sum = {hi_q[booth_pkg::width-1], hi_q} + addend;

    always_comb begin
        step_word.halves.hi = sum[booth_pkg::width-1:0];
        step_word.halves.lo = q_lo;
        // arithmetic shift with the sign of the widened sum
        shifted.full = {sum[booth_pkg::width], step_word.full[2*booth_pkg::width-1:1]};
    end

    // bit leaving A goes to the top of Q
    assign shift_in = shifted.halves.lo[booth_pkg::width-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hi_q <= '0;
        end else if (clear) begin
            hi_q <= '0;
        end else if (step && qr_sel) begin
            hi_q <= shifted.halves.hi;
        end
    end

    always_comb begin
        prod_word.halves.hi = hi_q;
        prod_word.halves.lo = q_lo;
    end

    assign product = prod_word.full;

endmodule

// ==== tb/booth_multiplier_tb.sv ====
module booth_multiplier_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 4 * booth_pkg::width + 20;
    localparam int random_count = 200;
    localparam int order_count = 100;

    logic clk;
    logic rst;
    logic src_valid;
    logic src_ready;
    logic signed [booth_pkg::width-1:0] multiplicand;
    logic signed [booth_pkg::width-1:0] multiplier;
    logic dest_valid;
    logic dest_ready;
    logic signed [2*booth_pkg::width-1:0] product;

    logic [31:0] rng_state;
    logic signed [2*booth_pkg::width-1:0] expected_q[$];  // results still owed by the DUT

    booth_multiplier booth_multiplier_inst (
        .clk          (clk),
        .rst          (rst),
        .src_valid    (src_valid),
        .src_ready    (src_ready),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .dest_valid   (dest_valid),
        .dest_ready   (dest_ready),
        .product      (product)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // widen both operands before the signed multiply
    function automatic logic signed [2*booth_pkg::width-1:0] model_product(
        input logic signed [booth_pkg::width-1:0] a,
        input logic signed [booth_pkg::width-1:0] b
    );
        logic signed [2*booth_pkg::width-1:0] a_ext;
        logic signed [2*booth_pkg::width-1:0] b_ext;
        a_ext = a;
        b_ext = b;
        return a_ext * b_ext;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic draw_operand(output logic signed [booth_pkg::width-1:0] value);
        logic [31:0] r;
        draw_random(r);
        value = r[booth_pkg::width-1:0];
    endtask

    task automatic stop_on_failure();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            stop_on_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: the %s handshake never completed", what);
        stop_on_failure();
    endtask

    // step to 1 ns past the rising edge where outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic send_operands(input logic signed [booth_pkg::width-1:0] a,
                                 input logic signed [booth_pkg::width-1:0] b);
        int cycles;
        cycles = 0;
        src_valid = 1'b1;
        multiplicand = a;
        multiplier = b;
        while (!src_ready) begin
            next_cycle();
            cycles++;
            if (cycles > timeout_cycles) begin
                report_timeout("input");
            end
        end
        next_cycle();  // transfer edge
        src_valid = 1'b0;
    endtask

    task automatic receive_product(input bit random_ready,
                                   output logic signed [2*booth_pkg::width-1:0] result);
        int cycles;
        bit done;
        logic [31:0] r;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            if (random_ready) begin
                draw_random(r);
                dest_ready = (r[1:0] != 2'b00);
            end else begin
                dest_ready = 1'b1;
            end
            if (dest_valid && dest_ready) begin
                result = product;
                done = 1'b1;
            end
            next_cycle();
            cycles++;
            if (!done && cycles > timeout_cycles) begin
                report_timeout("output");
            end
        end
        dest_ready = 1'b0;
    endtask

    task automatic multiply_and_check(input string name,
                                      input logic signed [booth_pkg::width-1:0] a,
                                      input logic signed [booth_pkg::width-1:0] b,
                                      input bit random_ready);
        logic signed [2*booth_pkg::width-1:0] got;
        send_operands(a, b);
        receive_product(random_ready, got);
        check_value(name, model_product(a, b), got);
    endtask

    task automatic check_reset_state();
        check_value("reset src_ready", 1, src_ready);
        check_value("reset dest_valid", 0, dest_valid);
    endtask

    task automatic run_random_products();
        logic signed [booth_pkg::width-1:0] a;
        logic signed [booth_pkg::width-1:0] b;
        for (int i = 0; i < random_count; i++) begin
            draw_operand(a);
            draw_operand(b);
            multiply_and_check("random product", a, b, 1'b1);
        end
    endtask

    task automatic run_corner_operands();
        logic signed [booth_pkg::width-1:0] most_neg;
        logic signed [booth_pkg::width-1:0] most_pos;
        most_neg = {1'b1, {(booth_pkg::width-1){1'b0}}};
        most_pos = {1'b0, {(booth_pkg::width-1){1'b1}}};
        multiply_and_check("min times min", most_neg, most_neg, 1'b0);
        multiply_and_check("min times minus one", most_neg, '1, 1'b0);
        multiply_and_check("min times zero", most_neg, '0, 1'b0);
        multiply_and_check("one times max", 1, most_pos, 1'b0);
    endtask

    task automatic hold_output();
        logic signed [booth_pkg::width-1:0] a;
        logic signed [booth_pkg::width-1:0] b;
        logic signed [booth_pkg::width-1:0] a2;
        logic signed [booth_pkg::width-1:0] b2;
        logic signed [2*booth_pkg::width-1:0] held;
        logic signed [2*booth_pkg::width-1:0] got;
        logic [31:0] r;
        int cycles;
        int hold_len;
        draw_operand(a);
        draw_operand(b);
        draw_operand(a2);
        draw_operand(b2);
        send_operands(a, b);
        dest_ready = 1'b0;
        cycles = 0;
        while (!dest_valid) begin
            next_cycle();
            cycles++;
            if (cycles > timeout_cycles) begin
                report_timeout("output");
            end
        end
        held = product;
        draw_random(r);
        hold_len = 1 + int'(r[3:0]);
        // second input offered while the sink stalls
        src_valid = 1'b1;
        multiplicand = a2;
        multiplier = b2;
        for (int i = 0; i < hold_len; i++) begin
            check_value("stall dest_valid", 1, dest_valid);
            check_value("stall product", held, product);
            check_value("stall src_ready", 0, src_ready);
            next_cycle();
        end
        dest_ready = 1'b1;
        check_value("stall dest_valid", 1, dest_valid);
        check_value("stall src_ready", 0, src_ready);
        next_cycle();  // output transfer
        dest_ready = 1'b0;
        check_value("held product", model_product(a, b), held);
        check_value("after output dest_valid", 0, dest_valid);
        check_value("after output src_ready", 1, src_ready);
        send_operands(a2, b2);
        receive_product(1'b0, got);
        check_value("product after stall", model_product(a2, b2), got);
    endtask

    task automatic stream_in_order();
        logic signed [booth_pkg::width-1:0] a;
        logic signed [booth_pkg::width-1:0] b;
        logic signed [2*booth_pkg::width-1:0] want;
        logic [31:0] r;
        bit src_fire;
        bit dest_fire;
        int sent;
        int received;
        int idle;
        sent = 0;
        received = 0;
        idle = 0;
        draw_operand(a);
        draw_operand(b);
        src_valid = 1'b1;
        multiplicand = a;
        multiplier = b;
        while (received < order_count) begin
            draw_random(r);
            dest_ready = (r[1:0] != 2'b00);
            src_fire = src_valid && src_ready;
            dest_fire = dest_valid && dest_ready;
            if (src_fire) begin
                expected_q.push_back(model_product(a, b));
                sent++;
            end
            if (dest_fire) begin
                check_value("order results pending", 1, expected_q.size());  // one in flight
                want = expected_q.pop_front();
                check_value("order product", want, product);
                received++;
                idle = 0;
            end
            next_cycle();
            idle++;
            if (idle > timeout_cycles) begin
                report_timeout("output");
            end
            if (src_fire) begin
                if (sent < order_count) begin
                    draw_operand(a);
                    draw_operand(b);
                    multiplicand = a;
                    multiplier = b;
                end else begin
                    src_valid = 1'b0;
                end
            end
        end
        dest_ready = 1'b0;
        src_valid = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        src_valid = 1'b0;
        dest_ready = 1'b0;
        multiplicand = '0;
        multiplier = '0;
        rng_state = 32'h20b5;

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;

        check_reset_state();
        run_random_products();
        run_corner_operands();
        hold_output();
        stream_in_order();

        $display("All tests passed");
        $finish;
    end

endmodule
